/* verilog/bch_pkg.sv */
`default_nettype none

package bch_pkg;

	// ******************************
	// Code constants
	// ******************************

	localparam int BCH_M = 4;                  // Field is GF(2^4).
	localparam int BCH_N = 15;                 // Codeword length in bits.
	localparam int BCH_DATA_BITS = 7;          // Message bits, sent first.
	localparam int BCH_ECC_BITS = 8;           // Parity bits, sent last.
	localparam int MSG_CNT_W = $clog2(BCH_DATA_BITS);

	// Generator x^8 + x^7 + x^6 + x^4 + 1 with the x^8 term implied.
	localparam logic [BCH_ECC_BITS-1:0] BCH_GEN_POLY = 8'hD1;

	// ******************************
	// Cycle counter sequence
	// ******************************

	localparam logic [BCH_M-1:0] LFSR_SEED = '1; // Any nonzero start works.

	// Fibonacci step for x^4 + x^3 + 1, which runs through all 15 nonzero states.
	function automatic logic [BCH_M-1:0] lfsr_step(input logic [BCH_M-1:0] s);
		return {s[BCH_M-2:0], s[BCH_M-1] ^ s[BCH_M-2]};
	endfunction

	// Counter value reached after a number of steps from the seed.
	function automatic logic [BCH_M-1:0] lfsr_count(input int steps);
		logic [BCH_M-1:0] s;
		s = LFSR_SEED;
		for (int i = 0; i < steps; i++) begin
			s = lfsr_step(s);
		end
		return s;
	endfunction

	localparam logic [BCH_M-1:0] ENC_SWITCH = lfsr_count(BCH_DATA_BITS - 2); // Last data load.
	localparam logic [BCH_M-1:0] ENC_DONE = lfsr_count(BCH_N - 3);           // Next cycle is last.

	// A codeword seen whole, or split into its message and parity fields.
	typedef union packed {
		logic [BCH_N-1:0] flat;
		struct packed {
			logic [BCH_DATA_BITS-1:0] msg;
			logic [BCH_ECC_BITS-1:0] ecc;
		} f;
	} bch_codeword_u;

endpackage

`default_nettype wire

/* verilog/enc_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Serial bit stream into and out of the BCH encoder.
interface enc_stream_if;

	logic start;    // First input bit of a message.
	logic data_in;  // Message bit, held until accepted.
	logic accepted; // Consumer takes the current output cycle.
	logic data_out; // Codeword bit, data first and parity after.
	logic first;    // First output cycle of a codeword.
	logic last;     // Last output cycle of a codeword.
	logic busy;     // Encoder is in the middle of a codeword.

	modport src (
		output start,
		output data_in,
		input accepted,
		input busy
	);

	modport enc (
		input start,
		input data_in,
		input accepted,
		output data_out,
		output first,
		output last,
		output busy
	);

	modport snk (
		input data_out,
		input first,
		input last,
		output accepted
	);

endinterface

`default_nettype wire

/* verilog/lfsr_counter.sv */
`timescale 1ns/1ps
`default_nettype none

// Cycle counter built from a maximal length LFSR.
// It is cheaper than a binary counter; terminal values come from the package.
module lfsr_counter (
	input logic clk,
	input logic rst,
	input logic restart,
	input logic ce,
	output logic [bch_pkg::BCH_M-1:0] count
);
	import bch_pkg::*;

	// ******************************
	// Counter register
	// ******************************

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			count <= LFSR_SEED; // Restart wins over a step.
		end else if (ce) begin
			count <= lfsr_step(count);
		end
	end

endmodule

`default_nettype wire

/* verilog/bch_encode.sv */
`timescale 1ns/1ps
`default_nettype none

// Serial systematic BCH(15,7) encoder.
// Message bits pass straight through while they are divided by the generator,
// then the remainder is shifted out MSB first as parity.
module bch_encode (
	input logic clk,
	input logic rst,
	enc_stream_if.enc stream
);
	import bch_pkg::*;

	logic [BCH_ECC_BITS-1:0] rem;    // Division remainder, becomes parity.
	logic [BCH_ECC_BITS-1:0] rem_fb; // Generator terms fed back this cycle.
	logic [BCH_M-1:0] count;
	logic fb;
	logic busy_q;
	logic last_q;
	logic load_rem; // Data bits after the first are still coming in.
	logic data_phase;

	// ******************************
	// Cycle counter
	// ******************************

	lfsr_counter u_counter (
		.clk(clk),
		.rst(rst),
		.restart(stream.start && stream.accepted),
		.ce(stream.accepted && busy_q),
		.count(count)
	);

	// ******************************
	// Feedback and outputs
	// ******************************

	// The remainder is treated as zero on the first bit.
	assign fb = stream.data_in ^ (stream.start ? 1'b0 : rem[BCH_ECC_BITS-1]);
	assign rem_fb = fb ? BCH_GEN_POLY : '0;

	assign data_phase = stream.start || load_rem;

	assign stream.first = stream.start && !busy_q;
	assign stream.last = last_q;
	assign stream.busy = busy_q;
	assign stream.data_out = data_phase ? stream.data_in : rem[BCH_ECC_BITS-1];

	// ******************************
	// Sequencing
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			last_q <= 1'b0;
			load_rem <= 1'b0;
		end else if (stream.accepted) begin
			if (stream.start) begin
				busy_q <= 1'b1;
				last_q <= 1'b0;
			end else if (count == ENC_DONE) begin
				last_q <= busy_q; // Ignore the count while idle.
			end else if (last_q) begin
				busy_q <= 1'b0;
				last_q <= 1'b0;
			end

			if (stream.start) begin
				load_rem <= 1'b1;
			end else if (count == ENC_SWITCH) begin
				load_rem <= 1'b0; // Seventh data bit is in.
			end
		end
	end

	// Remainder register, frozen whenever the cycle is not accepted.
	always_ff @(posedge clk) begin
		if (stream.accepted) begin
			if (stream.start) begin
				rem <= rem_fb;
			end else if (load_rem) begin
				rem <= {rem[BCH_ECC_BITS-2:0], 1'b0} ^ rem_fb;
			end else if (busy_q) begin
				rem <= {rem[BCH_ECC_BITS-2:0], 1'b0}; // Parity out.
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/msg_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

// Takes a message over four-phase req/ack and streams it MSB first.
module msg_serializer (
	input logic clk,
	input logic rst,
	input logic msg_req,
	input logic [bch_pkg::BCH_DATA_BITS-1:0] msg_data,
	output logic msg_ack,
	enc_stream_if.src stream
);
	import bch_pkg::*;

	logic [BCH_DATA_BITS-1:0] shreg;
	logic [MSG_CNT_W-1:0] bit_cnt;
	logic pend;    // Message captured, start not raised yet.
	logic sending; // Bits are going out.
	logic start_q;
	logic capture;

	assign capture = !pend && !sending && msg_req && !msg_ack && !stream.busy;

	assign stream.start = start_q;
	assign stream.data_in = shreg[BCH_DATA_BITS-1];

	// ******************************
	// Handshake and bit sequencing
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			msg_ack <= 1'b0;
			pend <= 1'b0;
			sending <= 1'b0;
			start_q <= 1'b0;
			bit_cnt <= '0;
		end else begin
			if (capture) begin
				msg_ack <= 1'b1;
				pend <= 1'b1;
			end else if (msg_ack && !msg_req) begin
				msg_ack <= 1'b0; // Requester has let go.
			end

			if (pend && !stream.busy) begin
				pend <= 1'b0;
				sending <= 1'b1;
				start_q <= 1'b1; // Marks the MSB.
				bit_cnt <= '0;
			end else if (sending && stream.accepted) begin
				start_q <= 1'b0;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == MSG_CNT_W'(BCH_DATA_BITS - 1)) begin
					sending <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			shreg <= msg_data;
		end else if (sending && stream.accepted) begin
			shreg <= {shreg[BCH_DATA_BITS-2:0], 1'b0}; // Next bit to the MSB.
		end
	end

endmodule

`default_nettype wire

/* verilog/code_collector.sv */
`timescale 1ns/1ps
`default_nettype none

// Gathers the serial codeword and offers it over four-phase req/ack.
// The stream is stalled from the end of a codeword until the
// handshake has fully completed.
module code_collector (
	input logic clk,
	input logic rst,
	enc_stream_if.snk stream,
	output logic code_req,
	output bch_pkg::bch_codeword_u code_word,
	input logic code_ack
);
	import bch_pkg::*;

	logic [BCH_N-1:0] shreg;
	logic [BCH_N-1:0] shreg_next;
	logic hold; // A finished word has not been handed over yet.

	assign stream.accepted = !hold;

	// The first bit starts a fresh word.
	assign shreg_next = stream.first ? {{(BCH_N-1){1'b0}}, stream.data_out}
		: {shreg[BCH_N-2:0], stream.data_out};

	// ******************************
	// Word assembly
	// ******************************

	always_ff @(posedge clk) begin
		if (stream.accepted) begin
			shreg <= shreg_next;
			if (stream.last) begin
				code_word.flat <= shreg_next; // Stays put during the handshake.
			end
		end
	end

	// ******************************
	// Output handshake
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			code_req <= 1'b0;
			hold <= 1'b0;
		end else begin
			if (stream.accepted && stream.last) begin
				code_req <= 1'b1;
				hold <= 1'b1;
			end else if (code_req && code_ack) begin
				code_req <= 1'b0;
			end else if (hold && !code_req && !code_ack) begin
				hold <= 1'b0; // Ack is back low; release the encoder.
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/bch_enc_top.sv */
`timescale 1ns/1ps
`default_nettype none

// BCH(15,7) encoder with four-phase message and codeword ports.
module bch_enc_top (
	input logic clk,
	input logic rst,
	input logic msg_req,
	input logic [bch_pkg::BCH_DATA_BITS-1:0] msg_data,
	output logic msg_ack,
	output logic code_req,
	output logic [bch_pkg::BCH_N-1:0] code_word,
	input logic code_ack
);
	import bch_pkg::*;

	bch_codeword_u code_word_u;

	enc_stream_if stream ();

	// ******************************
	// Blocks
	// ******************************

	msg_serializer u_serializer (
		.clk(clk),
		.rst(rst),
		.msg_req(msg_req),
		.msg_data(msg_data),
		.msg_ack(msg_ack),
		.stream(stream.src)
	);

	bch_encode u_encode (
		.clk(clk),
		.rst(rst),
		.stream(stream.enc)
	);

	code_collector u_collector (
		.clk(clk),
		.rst(rst),
		.stream(stream.snk),
		.code_req(code_req),
		.code_word(code_word_u),
		.code_ack(code_ack)
	);

	assign code_word = code_word_u.flat;

endmodule

`default_nettype wire

/* tests/bch_enc_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake and reset properties on the encoder ports.
module bch_enc_chk (
	input logic clk,
	input logic rst,
	input logic msg_req,
	input logic msg_ack,
	input logic code_req,
	input logic code_ack,
	input logic [bch_pkg::BCH_N-1:0] code_word
);
	int fail_count = 0; // Failed assertion count, read at the end of the run.

	reset_state: assert property (@(posedge clk) rst |=> (!msg_ack && !code_req))
		else begin
			$error("msg_ack or code_req is high in the cycle after reset");
			fail_count++;
		end

	word_stable: assert property (@(posedge clk) disable iff (rst)
		code_req |=> (!code_req || $stable(code_word)))
		else begin
			$error("code_word changed while code_req was high");
			fail_count++;
		end

	req_after_ack: assert property (@(posedge clk) disable iff (rst)
		$rose(code_req) |-> !code_ack)
		else begin
			$error("code_req rose while code_ack was still high");
			fail_count++;
		end

	ack_held: assert property (@(posedge clk) disable iff (rst)
		(msg_ack && msg_req) |=> msg_ack)
		else begin
			$error("msg_ack fell while msg_req was still high");
			fail_count++;
		end

endmodule

`default_nettype wire

/* tests/bch_enc_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

// Takes each codeword at the rising code_req and compares it with the trace.
module bch_enc_monitor (
	input logic clk,
	input logic rst,
	input logic code_req,
	input logic [bch_pkg::BCH_N-1:0] code_word,
	input logic report,
	input int assert_fails,
	output int errors,
	output int received
);
	import bch_pkg::*;

	localparam string TRACE_FILE = "tests/bch_enc_trace.txt";

	logic [BCH_DATA_BITS-1:0] exp_msg [$];
	logic [BCH_N-1:0] exp_word [$];
	logic [BCH_DATA_BITS-1:0] got_msg [$];
	logic [BCH_N-1:0] got_word [$];
	logic req_q;
	logic reported = 1'b0;
	int err_count = 0;
	int rx_count = 0;

	assign errors = err_count;
	assign received = rx_count;

	initial begin
		int fd;
		string line;
		logic [BCH_DATA_BITS-1:0] m;
		logic [BCH_N-1:0] c;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Monitor could not open %s, so nothing can be compared", TRACE_FILE);
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h", m, c) == 2) begin
					exp_msg.push_back(m);
					exp_word.push_back(c);
				end
			end
			$fclose(fd);
		end
	end

	// ******************************
	// Checks
	// ******************************

	task automatic check_word(input int idx, input bch_codeword_u cw);
		if (idx >= exp_word.size()) begin
			$display("Codeword %0d arrived after the last message of the trace", idx);
			err_count++;
		end else begin
			if (cw.flat !== exp_word[idx]) begin
				$display("** Error trace_encoding entry %0d: expected %h, actual %h",
					idx, exp_word[idx], cw.flat);
				err_count++;
			end
			if (cw.f.msg !== exp_msg[idx]) begin
				$display("** Error systematic_form entry %0d: expected %h, actual %h",
					idx, exp_msg[idx], cw.f.msg);
				err_count++;
			end
			if (exp_msg[idx] == '0 && cw.flat !== '0) begin
				$display("** Error zero_word entry %0d: expected %h, actual %h",
					idx, {BCH_N{1'b0}}, cw.flat);
				err_count++;
			end
		end
	endtask

	// Any message that is the XOR of two others must give the XOR of their codewords.
	task automatic check_linearity();
		logic [BCH_N-1:0] sum;
		for (int i = 0; i < got_word.size(); i++) begin
			for (int j = 0; j < got_word.size(); j++) begin
				for (int k = j + 1; k < got_word.size(); k++) begin
					if (i != j && i != k && (got_msg[j] ^ got_msg[k]) == got_msg[i]) begin
						sum = got_word[j] ^ got_word[k];
						if (got_word[i] !== sum) begin
							$display({"** Error linearity entry %0d from %0d and %0d:",
								" expected %h, actual %h"},
								i, j, k, sum, got_word[i]);
							err_count++;
						end
					end
				end
			end
		end
	endtask

	always @(posedge clk) begin
		bch_codeword_u cw;
		if (rst) begin
			req_q <= 1'b0;
		end else begin
			req_q <= code_req;
			if (code_req && !req_q) begin
				cw.flat = code_word;
				check_word(rx_count, cw);
				got_msg.push_back(cw.f.msg);
				got_word.push_back(cw.flat);
				rx_count++;
			end
			if (report && !reported) begin
				check_linearity();
				if (rx_count != exp_word.size()) begin
					$display("Received %0d codewords but %0d messages were sent",
						rx_count, exp_word.size());
					err_count++;
				end
				$display({"Summary: %0d of %0d codewords, %0d compare errors,",
					" %0d assertion failures"},
					rx_count, exp_word.size(), err_count, assert_fails);
				reported <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/bch_enc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_enc_tb;
	import bch_pkg::*;

	localparam string TRACE_FILE = "tests/bch_enc_trace.txt";

	logic clk;
	logic rst;
	logic msg_req;
	logic [BCH_DATA_BITS-1:0] msg_data;
	logic msg_ack;
	logic code_req;
	logic [BCH_N-1:0] code_word;
	logic code_ack;
	logic report;
	logic trace_ready = 1'b0;
	logic [BCH_DATA_BITS-1:0] messages [$];
	logic [31:0] rng_state;
	int errors;
	int received;
	int assert_fails;

	bch_enc_top bch_enc_top_i (
		.clk(clk),
		.rst(rst),
		.msg_req(msg_req),
		.msg_data(msg_data),
		.msg_ack(msg_ack),
		.code_req(code_req),
		.code_word(code_word),
		.code_ack(code_ack)
	);

	bind bch_enc_top bch_enc_chk chk_i (
		.clk(clk),
		.rst(rst),
		.msg_req(msg_req),
		.msg_ack(msg_ack),
		.code_req(code_req),
		.code_ack(code_ack),
		.code_word(code_word)
	);

	assign assert_fails = bch_enc_top_i.chk_i.fail_count;

	bch_enc_monitor monitor_i (
		.clk(clk),
		.rst(rst),
		.code_req(code_req),
		.code_word(code_word),
		.report(report),
		.assert_fails(assert_fails),
		.errors(errors),
		.received(received)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_messages(output bit ok);
		int fd;
		string line;
		logic [BCH_DATA_BITS-1:0] m;
		logic [BCH_N-1:0] c;
		fd = $fopen(TRACE_FILE, "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && $sscanf(line, "%h %h", m, c) == 2) begin
					messages.push_back(m);
				end
			end
			$fclose(fd);
		end
	endtask

	// Full four-phase cycle on the message port.
	task automatic send_message(input logic [BCH_DATA_BITS-1:0] m);
		msg_data <= m;
		msg_req <= 1'b1;
		@(posedge clk);
		while (!msg_ack) @(posedge clk);
		msg_req <= 1'b0;
		@(posedge clk);
		while (msg_ack) @(posedge clk);
	endtask

	// ******************************
	// Clock, stimulus and watchdog
	// ******************************

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		bit ok;
		rst = 1'b1;
		msg_req = 1'b0;
		msg_data = '0;
		code_ack = 1'b0;
		report = 1'b0;
		load_messages(ok);
		if (!ok) begin
			$display("Could not open the trace file %s", TRACE_FILE);
			$display("Test failed");
			$finish;
		end else begin
			trace_ready = 1'b1;
			repeat (3) @(posedge clk);
			rst <= 1'b0;
			foreach (messages[i]) begin
				send_message(messages[i]);
			end
			while (received < messages.size()) @(posedge clk);
			repeat (20) @(posedge clk); // Room for a stray extra codeword.
			report <= 1'b1;
			repeat (2) @(posedge clk);
			if (errors == 0 && assert_fails == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// Answers each code_req after a random delay of 0 to 7 cycles.
	initial begin
		int delay;
		rng_state = 32'h4f9c7a38;
		forever begin
			@(posedge clk);
			if (code_req && !code_ack) begin
				rng_state = lcg_next(rng_state);
				delay = int'(rng_state[18:16]);
				repeat (delay) @(posedge clk);
				code_ack <= 1'b1;
				@(posedge clk);
				while (code_req) @(posedge clk);
				code_ack <= 1'b0;
			end
		end
	end

	initial begin
		wait (trace_ready);
		repeat (messages.size() * 40 + 100) @(posedge clk);
		$display("Timeout: only %0d of %0d codewords arrived in time", received, messages.size());
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
verilog/bch_pkg.sv
verilog/enc_stream_if.sv
verilog/lfsr_counter.sv
verilog/bch_encode.sv
verilog/msg_serializer.sv
verilog/code_collector.sv
verilog/bch_enc_top.sv
tests/bch_enc_chk.sv
tests/bch_enc_monitor.sv
tests/bch_enc_tb.sv

/* Makefile */
VERILATOR = verilator
TOP = bch_enc_tb
FILELIST = all.f
OBJ_DIR = obj_dir
SIM_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
PASS_MSG = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/bch_enc_trace.txt */
# Columns: message (7 bits, hex) and expected codeword (15 bits, hex).
# Codeword is message * x^8 plus its remainder mod x^8 + x^7 + x^6 + x^4 + 1.
00 0000
01 01D1
02 0273
04 04E6
08 081D
10 103A
20 2074
40 40E8
7F 7FFF
55 55E5
2A 2A1A
3C 3CB5
0F 0F59
33 33EC
5A 5ABC
66 6609
6B 6B23
12 1249
79 796A
47 47AC
18 1827
5F 5F8B
7E 7E2E
23 23D6
5D 5DF8
31 319F
6D 6DB6
5C 5C29
1B 1B85
64 647A
